/* bench/fpu_ss_assertions.sv */
// Handshake checks on the result and memory request ports of the top level
// Stability checks are off while reset is asserted
module fpu_ss_assertions (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 result_valid_i,
  input logic                 result_ready_i,
  input fpu_ss_pkg::result_t  result_i,
  input logic                 mem_valid_i,
  input logic                 mem_ready_i,
  input fpu_ss_pkg::mem_req_t mem_req_i
);

  // Failed assertions so far, read by the testbench
  int fail_count = 0;

  // Result payload held until the core takes it
  result_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
  else begin
    fail_count++;
    $error("result valid dropped or payload changed before ready");
  end

  // Memory request held until the memory takes it
  mem_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i))
  else begin
    fail_count++;
    $error("memory valid dropped or request changed before ready");
  end

  // ----------------------------------------
  // Reset state
  // ----------------------------------------
  valids_low_after_reset_a : assert property (@(posedge clk_i)
    rst_i |=> !result_valid_i && !mem_valid_i)
  else begin
    fail_count++;
    $error("result or memory valid high in the cycle after reset");
  end

endmodule

bind fpu_ss_top fpu_ss_assertions i_assertions (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .result_valid_i (x_result_valid_o),
  .result_ready_i (x_result_ready_i),
  .result_i       (x_result_o),
  .mem_valid_i    (x_mem_valid_o),
  .mem_ready_i    (x_mem_ready_i),
  .mem_req_i      (x_mem_req_o)
);

/* bench/fpu_ss_tb.sv */
// Random offload stream checked against a shadow FP register file and memory
// Loads and stores hit a 64-word window; integer registers are not modelled
`include "fpu_ss_defines.svh"

module fpu_ss_tb;

  import fpu_ss_pkg::*;

  localparam int          NUM_INSTR      = 400;
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * 20;
  localparam int          MEM_WORDS      = 64;
  localparam logic [31:0] MEM_BASE       = 32'h0000_2000;

  logic        clk_i;
  logic        rst_i;
  logic        x_issue_valid_i;
  issue_req_t  x_issue_req_i;
  logic        x_mem_ready_i;
  logic        x_mem_result_valid_i;
  mem_result_t x_mem_result_i;
  logic        x_result_ready_i;
  logic        x_issue_ready_o;
  issue_resp_t x_issue_resp_o;
  logic        x_mem_valid_o;
  mem_req_t    x_mem_req_o;
  logic        x_result_valid_o;
  result_t     x_result_o;

  word_t    shadow_fpr [`FPU_SS_NUM_FPR];
  word_t    model_mem [MEM_WORDS];
  word_t    bench_mem [MEM_WORDS];
  result_t  exp_results [$];
  mem_req_t exp_mem_reqs [$];
  int       resp_errors;
  int       result_errors;
  int       mem_errors;
  int       other_errors;
  int       cycle_count;
  int       issued;
  logic     have_instr;
  id_t      next_id;
  int       load_wait;
  id_t      load_id;
  word_t    load_data;

  fpu_ss_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Data word for a memory address, distinct for every word
  function automatic word_t fill_word(input int idx);
    return ((MEM_BASE + idx * 4) * 32'h9e37_79b1) ^ 32'h3f80_0000;
  endfunction

  // Decode table of the supported subset
  function automatic logic decode(input instr_t instr, output op_kind_e kind);
    logic ok;
    kind = OP_FSGNJ;
    ok   = 1'b0;
    case (instr[6:0])
      `FPU_SS_OPC_LOAD_FP: begin
        kind = OP_FLW;
        ok   = (instr[14:12] == `FPU_SS_F3_WORD);
      end
      `FPU_SS_OPC_STORE_FP: begin
        kind = OP_FSW;
        ok   = (instr[14:12] == `FPU_SS_F3_WORD);
      end
      `FPU_SS_OPC_OP_FP: begin
        if (instr[31:25] == `FPU_SS_F7_FSGNJ) begin
          ok = 1'b1;
          case (instr[14:12])
            3'd0:    kind = OP_FSGNJ;
            3'd1:    kind = OP_FSGNJN;
            3'd2:    kind = OP_FSGNJX;
            default: ok = 1'b0;
          endcase
        end else if (instr[31:25] == `FPU_SS_F7_FMV_X_W) begin
          kind = OP_FMV_X_W;
          ok   = (instr[24:20] == 5'd0) && (instr[14:12] == 3'd0);
        end else if (instr[31:25] == `FPU_SS_F7_FMV_W_X) begin
          kind = OP_FMV_W_X;
          ok   = (instr[24:20] == 5'd0) && (instr[14:12] == 3'd0);
        end
      end
      default: ;
    endcase
    return ok;
  endfunction

  function automatic issue_resp_t expected_resp(input logic ok, input op_kind_e kind);
    issue_resp_t r;
    r.accept    = ok;
    r.writeback = ok && (kind == OP_FMV_X_W);
    r.loadstore = ok && ((kind == OP_FLW) || (kind == OP_FSW));
    return r;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_resp(input issue_resp_t exp, input issue_resp_t act);
    if (act !== exp) begin
      resp_errors++;
      $display("FAIL x_issue_resp_o: expected %h, got %h", exp, act);
    end
  endtask

  task automatic check_ready(input logic exp, input logic act);
    if (act !== exp) begin
      resp_errors++;
      $display("FAIL x_issue_ready_o: expected %h, got %h", exp, act);
    end
  endtask

  task automatic check_result(input result_t exp, input result_t act);
    if (act !== exp) begin
      result_errors++;
      $display("FAIL x_result_o: expected %h, got %h", exp, act);
    end
  endtask

  task automatic check_mem_req(input mem_req_t exp, input mem_req_t act);
    // Load requests carry no meaningful write data
    if (!exp.we) begin
      exp.wdata = act.wdata;
    end
    if (act !== exp) begin
      mem_errors++;
      $display("FAIL x_mem_req_o: expected %h, got %h", exp, act);
    end
  endtask

  // Mostly supported ops on f0..f7, a few near-miss and random encodings
  task automatic make_instr(output issue_req_t req);
    int          sel;
    fpr_addr_t   rd;
    fpr_addr_t   rs1;
    fpr_addr_t   rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    word_t       addr;
    sel  = $urandom_range(0, 15);
    rd   = fpr_addr_t'($urandom_range(0, 7));
    rs1  = fpr_addr_t'($urandom_range(0, 7));
    rs2  = fpr_addr_t'($urandom_range(0, 7));
    f3   = 3'($urandom_range(0, 2));
    imm  = 12'($urandom_range(0, 4095));
    addr = MEM_BASE + $urandom_range(0, MEM_WORDS - 1) * 4;
    req.id  = next_id;
    req.rs1 = addr - {{20{imm[11]}}, imm};
    case (sel)
      0, 1, 2: req.instr = {`FPU_SS_F7_FSGNJ, rs2, rs1, f3, rd, `FPU_SS_OPC_OP_FP};
      3, 4: begin
        req.rs1   = $urandom;
        req.instr = {`FPU_SS_F7_FMV_W_X, 5'd0, rs1, 3'd0, rd, `FPU_SS_OPC_OP_FP};
      end
      5, 6, 7: req.instr = {`FPU_SS_F7_FMV_X_W, 5'd0, rs1, 3'd0, rd, `FPU_SS_OPC_OP_FP};
      8, 9, 10: req.instr = {imm, rs1, `FPU_SS_F3_WORD, rd, `FPU_SS_OPC_LOAD_FP};
      11, 12: req.instr = {imm[11:5], rs2, rs1, `FPU_SS_F3_WORD, imm[4:0], `FPU_SS_OPC_STORE_FP};
      // FCLASS.S
      13: req.instr = {`FPU_SS_F7_FMV_X_W, 5'd0, rs1, 3'd1, rd, `FPU_SS_OPC_OP_FP};
      // Half-word load
      14: req.instr = {imm, rs1, 3'd1, rd, `FPU_SS_OPC_LOAD_FP};
      default: req.instr = $urandom;
    endcase
    next_id++;
  endtask

  // Model update for an accepted instruction, in issue order
  task automatic model_issue(input issue_req_t req, input op_kind_e kind);
    fpr_addr_t rd;
    fpr_addr_t rs1;
    fpr_addr_t rs2;
    word_t     a;
    word_t     b;
    word_t     addr;
    result_t   res;
    mem_req_t  mreq;
    rd  = req.instr[11:7];
    rs1 = req.instr[19:15];
    rs2 = req.instr[24:20];
    a   = shadow_fpr[rs1];
    b   = shadow_fpr[rs2];
    case (kind)
      OP_FSGNJ:   shadow_fpr[rd] = {b[31], a[30:0]};
      OP_FSGNJN:  shadow_fpr[rd] = {~b[31], a[30:0]};
      OP_FSGNJX:  shadow_fpr[rd] = {a[31] ^ b[31], a[30:0]};
      OP_FMV_W_X: shadow_fpr[rd] = req.rs1;
      OP_FMV_X_W: begin
        res.id   = req.id;
        res.rd   = rd;
        res.data = a;
        exp_results.push_back(res);
      end
      OP_FLW: begin
        addr       = req.rs1 + {{20{req.instr[31]}}, req.instr[31:20]};
        mreq.id    = req.id;
        mreq.addr  = addr;
        mreq.we    = 1'b0;
        mreq.wdata = '0;
        exp_mem_reqs.push_back(mreq);
        shadow_fpr[rd] = model_mem[addr[7:2]];
      end
      OP_FSW: begin
        addr       = req.rs1 + {{20{req.instr[31]}}, req.instr[31:25], req.instr[11:7]};
        mreq.id    = req.id;
        mreq.addr  = addr;
        mreq.we    = 1'b1;
        mreq.wdata = b;
        exp_mem_reqs.push_back(mreq);
        model_mem[addr[7:2]] = b;
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------
  // Per-cycle sampling and driving
  // ----------------------------------------
  task automatic sample_cycle();
    op_kind_e kind;
    logic     ok;
    if (x_issue_valid_i && x_issue_ready_o) begin
      ok = decode(x_issue_req_i.instr, kind);
      check_resp(expected_resp(ok, kind), x_issue_resp_o);
      if (ok) begin
        model_issue(x_issue_req_i, kind);
      end
      have_instr = 1'b0;
      issued++;
    end
    if (x_mem_valid_o && x_mem_ready_i) begin
      if (exp_mem_reqs.size() == 0) begin
        other_errors++;
        $display("Memory request id %h arrived while none was expected", x_mem_req_o.id);
      end else begin
        check_mem_req(exp_mem_reqs.pop_front(), x_mem_req_o);
      end
      if (x_mem_req_o.we) begin
        bench_mem[x_mem_req_o.addr[7:2]] = x_mem_req_o.wdata;
      end else begin
        if (load_wait != 0) begin
          other_errors++;
          $display("Load request issued while an earlier load was still pending");
        end
        load_wait = $urandom_range(1, 4);
        load_id   = x_mem_req_o.id;
        load_data = bench_mem[x_mem_req_o.addr[7:2]];
      end
    end
    if (x_result_valid_o && x_result_ready_i) begin
      if (exp_results.size() == 0) begin
        other_errors++;
        $display("Result id %h arrived while none was expected", x_result_o.id);
      end else begin
        check_result(exp_results.pop_front(), x_result_o);
      end
    end
  endtask

  task automatic drive_cycle();
    issue_req_t req;
    x_mem_ready_i        = ($urandom_range(0, 3) != 0);
    x_result_ready_i     = ($urandom_range(0, 3) != 0);
    x_mem_result_valid_i = 1'b0;
    if (load_wait > 0) begin
      load_wait--;
      if (load_wait == 0) begin
        x_mem_result_valid_i = 1'b1;
        x_mem_result_i.id    = load_id;
        x_mem_result_i.rdata = load_data;
      end
    end
    if (!have_instr && issued < NUM_INSTR && $urandom_range(0, 3) != 0) begin
      make_instr(req);
      x_issue_req_i = req;
      have_instr    = 1'b1;
    end
    x_issue_valid_i = have_instr;
  endtask

  initial begin : stimulus
    int seed;
    int total;
    seed = 77378;
    void'($urandom(seed));
    x_issue_valid_i      = 1'b0;
    x_issue_req_i        = '0;
    x_mem_ready_i        = 1'b0;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_i       = '0;
    x_result_ready_i     = 1'b0;
    rst_i                = 1'b1;
    resp_errors   = 0;
    result_errors = 0;
    mem_errors    = 0;
    other_errors  = 0;
    issued        = 0;
    have_instr    = 1'b0;
    next_id       = '0;
    load_wait     = 0;
    for (int i = 0; i < `FPU_SS_NUM_FPR; i++) begin
      shadow_fpr[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = fill_word(i);
      bench_mem[i] = fill_word(i);
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Empty issue register and scoreboard take any instruction
    check_ready(1'b1, x_issue_ready_o);
    while (issued < NUM_INSTR || exp_results.size() != 0 || exp_mem_reqs.size() != 0 ||
           load_wait != 0) begin
      @(negedge clk_i);
      sample_cycle();
      @(posedge clk_i);
      #1;
      drive_cycle();
    end
    repeat (2) @(posedge clk_i);
    total = resp_errors + result_errors + mem_errors + other_errors +
            i_dut.i_assertions.fail_count;
    $display("Issued %0d, errors: resp %0d, result %0d, mem %0d, other %0d, assertions %0d",
             issued, resp_errors, result_errors, mem_errors, other_errors,
             i_dut.i_assertions.fail_count);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Run limit, generous against about three cycles per instruction
  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d of %0d instructions issued",
             cycle_count, issued, NUM_INSTR);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* design/fpu_ss_defines.svh */
// Widths and RV32F encodings for the offload subset
// Single precision only; XLEN and register width are the same 32 bits
`ifndef FPU_SS_DEFINES_SVH
`define FPU_SS_DEFINES_SVH

// Data path and offload sizes
`define FPU_SS_XLEN    32
`define FPU_SS_NUM_FPR 32
`define FPU_SS_ID_W    4

// Major opcodes
`define FPU_SS_OPC_LOAD_FP  7'b0000111
`define FPU_SS_OPC_STORE_FP 7'b0100111
`define FPU_SS_OPC_OP_FP    7'b1010011

// funct7 for the supported OP-FP group
`define FPU_SS_F7_FSGNJ   7'b0010000
`define FPU_SS_F7_FMV_X_W 7'b1110000
`define FPU_SS_F7_FMV_W_X 7'b1111000

// Word-sized FLW and FSW
`define FPU_SS_F3_WORD 3'b010

`endif

/* design/fpu_ss_exec.sv */
// Bit-level single-precision ops, no arithmetic and no rounding
// Sign injection keeps NaN payloads untouched
`include "fpu_ss_defines.svh"

module fpu_ss_exec (
  input  fpu_ss_pkg::fp_op_t    op_i,
  input  fpu_ss_pkg::word_t     rs1_data_i,
  input  fpu_ss_pkg::word_t     rs2_data_i,
  output fpu_ss_pkg::exec_res_t exec_res_o
);

  import fpu_ss_pkg::*;

  localparam int SignBit = `FPU_SS_XLEN - 1;

  logic  sign_a;
  logic  sign_b;
  logic  sign_r;
  word_t sgnj_data;
  word_t data;
  word_t addr;

  assign sign_a = rs1_data_i[SignBit];
  assign sign_b = rs2_data_i[SignBit];

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  always_comb begin
    case (op_i.kind)
      OP_FSGNJN: sign_r = ~sign_b;
      OP_FSGNJX: sign_r = sign_a ^ sign_b;
      default:   sign_r = sign_b;
    endcase
  end

  assign sgnj_data = {sign_r, rs1_data_i[SignBit-1:0]};

  // Result data per kind
  always_comb begin
    case (op_i.kind)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: data = sgnj_data;
      OP_FMV_X_W: data = rs1_data_i;
      OP_FMV_W_X: data = op_i.int_op;
      // store data for FSW, unused by FLW
      default:    data = rs2_data_i;
    endcase
  end

  // Effective address for FLW and FSW
  assign addr = op_i.int_op + op_i.imm;

  always_comb begin
    exec_res_o.kind = op_i.kind;
    exec_res_o.rd   = op_i.rd;
    exec_res_o.data = data;
    exec_res_o.addr = addr;
    exec_res_o.id   = op_i.id;
  end

endmodule

/* design/fpu_ss_issue.sv */
// Decode, accept response, busy scoreboard and one-entry issue register
// No forwarding: a source or destination that is still busy stalls issue
`include "fpu_ss_defines.svh"

module fpu_ss_issue (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    x_issue_valid_i,
  input  fpu_ss_pkg::issue_req_t  x_issue_req_i,
  input  logic                    exec_ready_i,
  input  fpu_ss_pkg::fpr_wr_t     fpr_wr_i,
  output logic                    x_issue_ready_o,
  output fpu_ss_pkg::issue_resp_t x_issue_resp_o,
  output logic                    op_valid_o,
  output fpu_ss_pkg::fp_op_t      op_o
);

  import fpu_ss_pkg::*;

  instr_t                     instr;
  logic [6:0]                 opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  fpr_addr_t                  rs1_addr;
  fpr_addr_t                  rs2_addr;
  fpr_addr_t                  rd_addr;
  op_kind_e                   kind;
  logic                       supported;
  logic                       reads_rs1;
  logic                       reads_rs2;
  logic                       writes_rd;
  logic                       dep_rs;
  logic                       dep_rd;
  logic                       slot_free;
  logic                       issue_fire;
  word_t                      imm;
  logic [`FPU_SS_NUM_FPR-1:0] busy_q;
  logic [`FPU_SS_NUM_FPR-1:0] busy_d;
  logic                       op_valid_q;
  fp_op_t                     op_q;

  assign instr    = x_issue_req_i.instr;
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];

  // ----------------------------------------
  // Predecode
  // ----------------------------------------
  always_comb begin
    kind      = OP_FSGNJ;
    supported = 1'b0;
    case (opcode)
      `FPU_SS_OPC_LOAD_FP: begin
        kind      = OP_FLW;
        supported = (funct3 == `FPU_SS_F3_WORD);
      end
      `FPU_SS_OPC_STORE_FP: begin
        kind      = OP_FSW;
        supported = (funct3 == `FPU_SS_F3_WORD);
      end
      `FPU_SS_OPC_OP_FP: begin
        case (funct7)
          `FPU_SS_F7_FSGNJ: begin
            supported = 1'b1;
            case (funct3)
              3'b000:  kind = OP_FSGNJ;
              3'b001:  kind = OP_FSGNJN;
              3'b010:  kind = OP_FSGNJX;
              default: supported = 1'b0;
            endcase
          end
          `FPU_SS_F7_FMV_X_W: begin
            // funct3 001 here is FCLASS, not supported
            kind      = OP_FMV_X_W;
            supported = (funct3 == 3'b000) && (rs2_addr == '0);
          end
          `FPU_SS_F7_FMV_W_X: begin
            kind      = OP_FMV_W_X;
            supported = (funct3 == 3'b000) && (rs2_addr == '0);
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  // Register usage per kind; FSW stores the FP register in rs2
  always_comb begin
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    writes_rd = 1'b0;
    case (kind)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
        writes_rd = 1'b1;
      end
      OP_FMV_X_W:        reads_rs1 = 1'b1;
      OP_FMV_W_X, OP_FLW: writes_rd = 1'b1;
      OP_FSW:            reads_rs2 = 1'b1;
      default: ;
    endcase
  end

  // Sign-extended I or S immediate
  always_comb begin
    if (kind == OP_FSW) begin
      imm = {{(`FPU_SS_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    end else begin
      imm = {{(`FPU_SS_XLEN-12){instr[31]}}, instr[31:20]};
    end
  end

  assign dep_rs = (reads_rs1 & busy_q[rs1_addr]) | (reads_rs2 & busy_q[rs2_addr]);
  assign dep_rd = writes_rd & busy_q[rd_addr];

  // Rejected instructions only wait for a free slot
  assign slot_free       = ~op_valid_q | exec_ready_i;
  assign x_issue_ready_o = slot_free & ~(supported & (dep_rs | dep_rd));
  assign issue_fire      = x_issue_valid_i & x_issue_ready_o & supported;

  assign x_issue_resp_o.accept    = supported;
  assign x_issue_resp_o.writeback = supported & (kind == OP_FMV_X_W);
  assign x_issue_resp_o.loadstore = supported & ((kind == OP_FLW) | (kind == OP_FSW));

  // ----------------------------------------
  // Scoreboard and issue register
  // ----------------------------------------
  always_comb begin
    busy_d = busy_q;
    if (fpr_wr_i.we) begin
      busy_d[fpr_wr_i.addr] = 1'b0;
    end
    if (issue_fire && writes_rd) begin
      busy_d[rd_addr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= '0;
      op_valid_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
      if (issue_fire) begin
        op_valid_q <= 1'b1;
      end else if (exec_ready_i) begin
        op_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      op_q.kind   <= kind;
      op_q.rd     <= rd_addr;
      op_q.rs1    <= rs1_addr;
      op_q.rs2    <= rs2_addr;
      op_q.int_op <= x_issue_req_i.rs1;
      op_q.imm    <= imm;
      op_q.id     <= x_issue_req_i.id;
    end
  end

  assign op_valid_o = op_valid_q;
  assign op_o       = op_q;

endmodule

/* design/fpu_ss_pkg.sv */
// Types for the RV32F offload subset with seven instructions
// Memory transfers are word only, there is no byte enable or size field
`include "fpu_ss_defines.svh"

package fpu_ss_pkg;

  typedef logic [`FPU_SS_XLEN-1:0]            word_t;
  typedef logic [31:0]                        instr_t;
  typedef logic [$clog2(`FPU_SS_NUM_FPR)-1:0] fpr_addr_t;
  typedef logic [`FPU_SS_ID_W-1:0]            id_t;

  // Decoded operation kind
  typedef enum logic [2:0] {
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMV_X_W,
    OP_FMV_W_X,
    OP_FLW,
    OP_FSW
  } op_kind_e;

  // ----------------------------------------
  // Issue interface
  // ----------------------------------------
  typedef struct packed {
    instr_t instr;
    word_t  rs1;
    id_t    id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  // ----------------------------------------
  // Internal pipeline
  // ----------------------------------------
  typedef struct packed {
    op_kind_e  kind;
    fpr_addr_t rd;
    fpr_addr_t rs1;
    fpr_addr_t rs2;
    word_t     int_op;
    word_t     imm;
    id_t       id;
  } fp_op_t;

  typedef struct packed {
    op_kind_e  kind;
    fpr_addr_t rd;
    word_t     data;
    word_t     addr;
    id_t       id;
  } exec_res_t;

  typedef struct packed {
    logic      we;
    fpr_addr_t addr;
    word_t     data;
  } fpr_wr_t;

  // ----------------------------------------
  // Result and memory interfaces
  // ----------------------------------------
  typedef struct packed {
    id_t       id;
    fpr_addr_t rd;
    word_t     data;
  } result_t;

  typedef struct packed {
    id_t   id;
    word_t addr;
    logic  we;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    id_t   id;
    word_t rdata;
  } mem_result_t;

endpackage

/* design/fpu_ss_regfile.sv */
// Floating-point register file, two read ports and one write port
// Reads are combinational and see the old value on a same-cycle write
`include "fpu_ss_defines.svh"

module fpu_ss_regfile (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  fpu_ss_pkg::fpr_addr_t raddr_a_i,
  input  fpu_ss_pkg::fpr_addr_t raddr_b_i,
  input  fpu_ss_pkg::fpr_wr_t   fpr_wr_i,
  output fpu_ss_pkg::word_t     rdata_a_o,
  output fpu_ss_pkg::word_t     rdata_b_o
);

  import fpu_ss_pkg::*;

  word_t regs_q [`FPU_SS_NUM_FPR];

  // All registers start at +0.0
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `FPU_SS_NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (fpr_wr_i.we) begin
      regs_q[fpr_wr_i.addr] <= fpr_wr_i.data;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* design/fpu_ss_top.sv */
// Offload coprocessor top for FLW, FSW, FSGNJ*.S and FMV between X and F
// No commit interface: every accepted instruction is executed
module fpu_ss_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    x_issue_valid_i,
  input  fpu_ss_pkg::issue_req_t  x_issue_req_i,
  input  logic                    x_mem_ready_i,
  input  logic                    x_mem_result_valid_i,
  input  fpu_ss_pkg::mem_result_t x_mem_result_i,
  input  logic                    x_result_ready_i,
  output logic                    x_issue_ready_o,
  output fpu_ss_pkg::issue_resp_t x_issue_resp_o,
  output logic                    x_mem_valid_o,
  output fpu_ss_pkg::mem_req_t    x_mem_req_o,
  output logic                    x_result_valid_o,
  output fpu_ss_pkg::result_t     x_result_o
);

  import fpu_ss_pkg::*;

  logic      op_valid;
  fp_op_t    op;
  word_t     rs1_data;
  word_t     rs2_data;
  exec_res_t exec_res;
  logic      exec_ready;
  fpr_wr_t   fpr_wr;

  // Input side
  fpu_ss_issue i_issue (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .x_issue_valid_i (x_issue_valid_i),
    .x_issue_req_i   (x_issue_req_i),
    .exec_ready_i    (exec_ready),
    .fpr_wr_i        (fpr_wr),
    .x_issue_ready_o (x_issue_ready_o),
    .x_issue_resp_o  (x_issue_resp_o),
    .op_valid_o      (op_valid),
    .op_o            (op)
  );

  fpu_ss_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (op.rs1),
    .raddr_b_i (op.rs2),
    .fpr_wr_i  (fpr_wr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  fpu_ss_exec i_exec (
    .op_i       (op),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .exec_res_o (exec_res)
  );

  // Output side
  fpu_ss_writeback i_writeback (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .res_valid_i          (op_valid),
    .exec_res_i           (exec_res),
    .x_result_ready_i     (x_result_ready_i),
    .x_mem_ready_i        (x_mem_ready_i),
    .x_mem_result_valid_i (x_mem_result_valid_i),
    .x_mem_result_i       (x_mem_result_i),
    .exec_ready_o         (exec_ready),
    .x_result_valid_o     (x_result_valid_o),
    .x_result_o           (x_result_o),
    .x_mem_valid_o        (x_mem_valid_o),
    .x_mem_req_o          (x_mem_req_o),
    .fpr_wr_o             (fpr_wr)
  );

endmodule

/* design/fpu_ss_writeback.sv */
// Result register, memory request, pending load and FP write arbitration
// One memory operation in flight; a load result wins the write port
module fpu_ss_writeback (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    res_valid_i,
  input  fpu_ss_pkg::exec_res_t   exec_res_i,
  input  logic                    x_result_ready_i,
  input  logic                    x_mem_ready_i,
  input  logic                    x_mem_result_valid_i,
  input  fpu_ss_pkg::mem_result_t x_mem_result_i,
  output logic                    exec_ready_o,
  output logic                    x_result_valid_o,
  output fpu_ss_pkg::result_t     x_result_o,
  output logic                    x_mem_valid_o,
  output fpu_ss_pkg::mem_req_t    x_mem_req_o,
  output fpu_ss_pkg::fpr_wr_t     fpr_wr_o
);

  import fpu_ss_pkg::*;

  logic      is_fp_dst;
  logic      is_mv_x;
  logic      is_load;
  logic      is_mem;
  logic      load_wr;
  logic      item_done;
  logic      res_valid_q;
  result_t   res_q;
  logic      load_pend_q;
  fpr_addr_t load_rd_q;

  // Kinds that write the FP register file directly
  assign is_fp_dst = (exec_res_i.kind == OP_FSGNJ) | (exec_res_i.kind == OP_FSGNJN) |
                     (exec_res_i.kind == OP_FSGNJX) | (exec_res_i.kind == OP_FMV_W_X);
  assign is_mv_x   = (exec_res_i.kind == OP_FMV_X_W);
  assign is_load   = (exec_res_i.kind == OP_FLW);
  assign is_mem    = is_load | (exec_res_i.kind == OP_FSW);

  // Load data arrives only while a load is pending
  assign load_wr = load_pend_q & x_mem_result_valid_i;

  // ----------------------------------------
  // Memory request
  // ----------------------------------------
  assign x_mem_valid_o = res_valid_i & is_mem & ~load_pend_q;

  always_comb begin
    x_mem_req_o.id    = exec_res_i.id;
    x_mem_req_o.addr  = exec_res_i.addr;
    x_mem_req_o.we    = ~is_load;
    x_mem_req_o.wdata = exec_res_i.data;
  end

  // Completion of the item in the issue register
  always_comb begin
    item_done = 1'b0;
    if (res_valid_i) begin
      if (is_fp_dst) begin
        item_done = ~load_wr;
      end else if (is_mv_x) begin
        item_done = ~res_valid_q | x_result_ready_i;
      end else if (is_mem) begin
        item_done = x_mem_valid_o & x_mem_ready_i;
      end
    end
  end

  assign exec_ready_o = item_done;

  // ----------------------------------------
  // FP register write port
  // ----------------------------------------
  always_comb begin
    fpr_wr_o.we   = 1'b0;
    fpr_wr_o.addr = exec_res_i.rd;
    fpr_wr_o.data = exec_res_i.data;
    if (load_wr) begin
      fpr_wr_o.we   = 1'b1;
      fpr_wr_o.addr = load_rd_q;
      fpr_wr_o.data = x_mem_result_i.rdata;
    end else if (res_valid_i && is_fp_dst) begin
      fpr_wr_o.we = 1'b1;
    end
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_q <= 1'b0;
      load_pend_q <= 1'b0;
    end else begin
      if (item_done && is_mv_x) begin
        res_valid_q <= 1'b1;
      end else if (x_result_ready_i) begin
        res_valid_q <= 1'b0;
      end
      if (item_done && is_load) begin
        load_pend_q <= 1'b1;
      end else if (load_wr) begin
        load_pend_q <= 1'b0;
      end
    end
  end

  // Payload of the result register and the pending load
  always_ff @(posedge clk_i) begin
    if (item_done && is_mv_x) begin
      res_q.id   <= exec_res_i.id;
      res_q.rd   <= exec_res_i.rd;
      res_q.data <= exec_res_i.data;
    end
    if (item_done && is_load) begin
      load_rd_q <= exec_res_i.rd;
    end
  end

  assign x_result_valid_o = res_valid_q;
  assign x_result_o       = res_q;

endmodule

/* src.f */
+incdir+design
design/fpu_ss_pkg.sv
design/fpu_ss_issue.sv
design/fpu_ss_regfile.sv
design/fpu_ss_exec.sv
design/fpu_ss_writeback.sv
design/fpu_ss_top.sv
bench/fpu_ss_assertions.sv
bench/fpu_ss_tb.sv
